/* flist.f */
+incdir+verification
logic/pong_pkg.sv
logic/button_conditioner.sv
logic/ping_pong_counter.sv
logic/display_scan.sv
logic/pong_display_top.sv
verification/pong_tb.sv

/* logic/button_conditioner.sv */
`timescale 1ns/1ps
`default_nettype none

module button_conditioner
    import pong_pkg::*;
#(
    parameter int debounce_bits = debounce_bits_default
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flip,
    output logic flip_pulse
);

    logic [debounce_bits-1:0] sample_div;
    logic                     sample_tick;
    logic [3:0]               history;
    logic                     debounced;
    logic                     debounced_q;

    assign sample_tick = &sample_div;
    assign debounced   = &history; // Four high samples in a row

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_div <= '0;
        end else begin
            sample_div <= sample_div + debounce_bits'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= 4'b0000;
        end else if (sample_tick) begin
            history <= {history[2:0], flip};
        end
    end

    // Rising edge of the debounced level, one cycle wide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debounced_q <= 1'b0;
            flip_pulse  <= 1'b0;
        end else begin
            debounced_q <= debounced;
            flip_pulse  <= debounced & ~debounced_q;
        end
    end

endmodule

`default_nettype wire

/* logic/display_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module display_scan
    import pong_pkg::*;
#(
    parameter int scan_bits = scan_bits_default
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [count_w-1:0]     count,
    input  logic                   direction,
    output logic [digit_count-1:0] an,
    output logic [6:0]             segs
);

    logic [scan_bits-1:0] scan_div;
    logic [1:0]           digit;
    logic [6:0]           seg_ones;
    logic [6:0]           seg_tens;
    logic [6:0]           seg_dir;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_div <= '0;
        end else begin
            scan_div <= scan_div + scan_bits'(1);
        end
    end

    // Each digit gets a quarter of the scan period
    assign digit = scan_div[scan_bits-1 -: 2];

    // One anode low at a time
    assign an = ~(digit_count'(1) << digit);

    assign seg_ones = seg_digit_table[count];
    assign seg_tens = (count > count_w'(9)) ? seg_one : seg_zero;
    assign seg_dir  = direction ? seg_dir_up : seg_dir_down;

    always_comb begin
        case (digit)
            2'd0:    segs = seg_ones;
            2'd1:    segs = seg_tens;
            2'd2:    segs = seg_dir;
            2'd3:    segs = seg_dir; // Glyph repeated on both upper digits
            default: segs = seg_blank;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ping_pong_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module ping_pong_counter
    import pong_pkg::*;
#(
    parameter int step_bits = step_bits_default
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               flip_pulse,
    input  logic [count_w-1:0] max,
    input  logic [count_w-1:0] min,
    output logic [count_w-1:0] count,
    output logic               direction
);

    logic [step_bits-1:0] step_div;
    logic                 step_tick;
    logic                 active;
    logic [count_w-1:0]   next_count;
    logic                 next_dir;
    logic                 stepped_dir;

    // Free-running step divider
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_div <= '0;
        end else begin
            step_div <= step_div + step_bits'(1);
        end
    end

    assign step_tick = &step_div;

    // Frozen outside the bounds or with an empty range
    assign active = en
                 && (min <= count)
                 && (count <= max)
                 && (max != min);

    always_comb begin
        next_count = count;
        next_dir   = direction;
        if (active) begin
            if (count == max) begin
                next_count = count - count_w'(1); // Bounce off the top
                next_dir   = 1'b0;
            end else if (count == min) begin
                next_count = count + count_w'(1);
                next_dir   = 1'b1;
            end else if (direction) begin
                next_count = count + count_w'(1);
            end else begin
                next_count = count - count_w'(1);
            end
        end
    end

    // Direction after this cycle's step, before any manual flip
    assign stepped_dir = step_tick ? next_dir : direction;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= min;
        end else if (step_tick) begin
            count <= next_count;
        end
    end

    // A flip inverts whatever direction the step would leave behind,
    // so it governs the step after this one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            direction <= 1'b1; // Count up out of reset
        end else if (flip_pulse && active) begin
            direction <= ~stepped_dir;
        end else begin
            direction <= stepped_dir;
        end
    end

endmodule

`default_nettype wire

/* logic/pong_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pong_display_top
    import pong_pkg::*;
#(
    parameter int step_bits     = step_bits_default,
    parameter int scan_bits     = scan_bits_default,
    parameter int debounce_bits = debounce_bits_default
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic                   flip,
    input  logic [count_w-1:0]     max,
    input  logic [count_w-1:0]     min,
    output logic [digit_count-1:0] an,
    output logic [6:0]             segs
);

    logic               flip_pulse;
    logic [count_w-1:0] count;
    logic               direction;

    // Raw button to single-cycle press pulse
    button_conditioner #(
        .debounce_bits (debounce_bits)
    ) u_button (
        .clk        (clk),
        .rst_n      (rst_n),
        .flip       (flip),
        .flip_pulse (flip_pulse)
    );

    ping_pong_counter #(
        .step_bits (step_bits)
    ) u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .flip_pulse (flip_pulse),
        .max        (max),
        .min        (min),
        .count      (count),
        .direction  (direction)
    );

    // Multiplexed four-digit output
    display_scan #(
        .scan_bits (scan_bits)
    ) u_display (
        .clk       (clk),
        .rst_n     (rst_n),
        .count     (count),
        .direction (direction),
        .an        (an),
        .segs      (segs)
    );

endmodule

`default_nettype wire

/* logic/pong_pkg.sv */
`default_nettype none

package pong_pkg;

    localparam int count_w     = 4;
    localparam int digit_count = 4;

    // Divider widths for a board clock
    localparam int step_bits_default     = 26;
    localparam int scan_bits_default     = 19;
    localparam int debounce_bits_default = 13;

    // Active-low segment patterns in gfedcba bit order
    localparam logic [6:0] seg_blank    = 7'b1111111;
    localparam logic [6:0] seg_dir_up   = 7'b1011100; // Upper arc
    localparam logic [6:0] seg_dir_down = 7'b1100011; // Lower arc
    localparam logic [6:0] seg_one      = 7'b1111001;
    localparam logic [6:0] seg_zero     = 7'b1000000;

    // Values 10 to 15 reuse the ones digit
    localparam logic [6:0] seg_digit_table [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b1000000, 7'b1111001,
        7'b0100100, 7'b0110000, 7'b0011001, 7'b0010010
    };

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module pong_tb \
    -f flist.f \
    --Mdir obj_dir \
    -o pong_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/pong_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* verification/pong_model.svh */
`ifndef PONG_MODEL_SVH
`define PONG_MODEL_SVH

// Cycle model stepped once per rising edge from the values seen at that edge
logic [step_w-1:0]  m_step_div;
logic [scan_w-1:0]  m_scan_div;
logic [deb_w-1:0]   m_deb_div;
logic [3:0]         m_samples;
logic               m_pressed_before;
logic               m_pulse;
logic [count_w-1:0] m_count;
logic               m_up;

function automatic logic [3:0] anode_for(input logic [1:0] d);
    logic [3:0] a;
    case (d)
        2'd0:    a = 4'b1110;
        2'd1:    a = 4'b1101;
        2'd2:    a = 4'b1011;
        default: a = 4'b0111;
    endcase
    return a;
endfunction

function automatic logic [6:0] glyph_for(input logic [1:0] d,
                                         input logic [count_w-1:0] c,
                                         input logic up);
    logic [6:0] g;
    case (d)
        2'd0:    g = seg_digit_table[c];
        2'd1:    g = (c > 4'd9) ? seg_one : seg_zero;
        default: g = up ? seg_dir_up : seg_dir_down; // Both upper digits
    endcase
    return g;
endfunction

function automatic logic [3:0] an_expected();
    return anode_for(m_scan_div[scan_w-1 -: 2]);
endfunction

function automatic logic [6:0] segs_expected();
    return glyph_for(m_scan_div[scan_w-1 -: 2], m_count, m_up);
endfunction

task automatic model_clock(input logic r, input logic e, input logic f,
                           input logic [count_w-1:0] hi,
                           input logic [count_w-1:0] lo);
    logic               running;
    logic               step_now;
    logic               sample_now;
    logic               pressed;
    logic               up_next;
    logic [count_w-1:0] count_next;
    if (!r) begin
        m_step_div       = '0;
        m_scan_div       = '0;
        m_deb_div        = '0;
        m_samples        = 4'b0000;
        m_pressed_before = 1'b0;
        m_pulse          = 1'b0;
        m_count          = lo;
        m_up             = 1'b1;
    end else begin
        running    = e && (lo <= m_count) && (m_count <= hi) && (hi != lo);
        step_now   = (m_step_div == {step_w{1'b1}});
        sample_now = (m_deb_div == {deb_w{1'b1}});
        pressed    = (m_samples == 4'b1111);
        count_next = m_count;
        up_next    = m_up;
        if (step_now && running) begin
            if (m_count == hi) begin
                count_next = m_count - 1'b1;
                up_next    = 1'b0;
            end else if (m_count == lo) begin
                count_next = m_count + 1'b1;
                up_next    = 1'b1;
            end else if (m_up) begin
                count_next = m_count + 1'b1;
            end else begin
                count_next = m_count - 1'b1;
            end
        end
        if (m_pulse && running) begin
            up_next = !up_next; // Manual reversal on top of the step
        end
        m_count          = count_next;
        m_up             = up_next;
        m_pulse          = pressed && !m_pressed_before;
        m_pressed_before = pressed;
        if (sample_now) begin
            m_samples = {m_samples[2:0], f};
        end
        m_step_div = m_step_div + 1'b1;
        m_scan_div = m_scan_div + 1'b1;
        m_deb_div  = m_deb_div + 1'b1;
    end
endtask

`endif

/* verification/pong_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pong_tb
    import pong_pkg::*;
();

    localparam int step_w      = 6;
    localparam int scan_w      = 4;
    localparam int deb_w       = 2;
    localparam int clk_period  = 100;
    localparam int drive_delay = 10;
    localparam int step_cycles = 1 << step_w;

    // Test lengths in clock cycles
    localparam int len_reset  = 4;
    localparam int len_scan   = 1 << scan_w;
    localparam int len_bounce = 40 * step_cycles;
    localparam int len_hold   = 8 * step_cycles;
    localparam int len_flip   = 10 * step_cycles;
    localparam int len_frozen = 8 * step_cycles;
    localparam int len_random = 3000;
    localparam int len_total  = len_reset + len_scan + len_bounce + len_hold
                              + len_flip + len_frozen + len_random;
    localparam int margin     = 500;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    logic                   flip;
    logic [count_w-1:0]     bound_max;
    logic [count_w-1:0]     bound_min;
    logic [digit_count-1:0] an;
    logic [6:0]             segs;

    logic [count_w-1:0] keep_max;
    logic [count_w-1:0] keep_min;
    int                 seed;
    int                 errors;
    int                 checks;
    int                 tests_run;
    int                 tests_failed;

    `include "pong_model.svh"

    pong_display_top #(
        .step_bits     (step_w),
        .scan_bits     (scan_w),
        .debounce_bits (deb_w)
    ) uut (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .flip  (flip),
        .max   (bound_max),
        .min   (bound_min),
        .an    (an),
        .segs  (segs)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (len_total + margin));
        $display("TIMEOUT: the tests did not finish within %0d clock cycles", len_total + margin);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - start);
        end
    endtask

    // Advance the model one clock, compare the display, then drive the next inputs
    task automatic run_cycle(input logic r, input logic e, input logic f,
                             input logic [count_w-1:0] hi,
                             input logic [count_w-1:0] lo);
        @(posedge clk);
        model_clock(rst_n, en, flip, bound_max, bound_min);
        #(drive_delay / 2);
        check_value("anodes", 32'(an_expected()), 32'(an));
        check_value("segments", 32'(segs_expected()), 32'(segs));
        #(drive_delay - drive_delay / 2);
        rst_n     = r;
        en        = e;
        flip      = f;
        bound_max = hi;
        bound_min = lo;
    endtask

    // Leaves the clock just past a step tick
    task automatic align_to_step();
        int guard;
        guard = 0;
        run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
        while (m_step_div != '0 && guard < step_cycles) begin
            run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
            guard++;
        end
    endtask

    task automatic reset_and_scan();
        int         start;
        int         n;
        logic [1:0] d;
        start     = errors;
        keep_min  = count_w'(rand_range(0, 9));
        keep_max  = count_w'(rand_range(10, 15));
        bound_min = keep_min;
        bound_max = keep_max;
        repeat (len_reset - 1) run_cycle(1'b0, 1'b0, 1'b0, keep_max, keep_min);
        run_cycle(1'b1, 1'b0, 1'b0, keep_max, keep_min);
        for (n = 1; n <= len_scan; n++) begin
            run_cycle(1'b1, 1'b0, 1'b0, keep_max, keep_min);
            d = 2'((n >> (scan_w - 2)) & 3); // Top two divider bits
            check_value("scan order", 32'(anode_for(d)), 32'(an));
            check_value("reset display", 32'(glyph_for(d, keep_min, 1'b1)), 32'(segs));
        end
        finish_test("reset and scan", start);
    endtask

    task automatic bounce_between_bounds();
        int                 start;
        int                 n;
        int                 diff;
        logic [count_w-1:0] last;
        logic               seen_min;
        logic               seen_max;
        start    = errors;
        last     = uut.count;
        seen_min = 1'b0;
        seen_max = 1'b0;
        for (n = 0; n < len_bounce; n++) begin
            run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
            if (uut.count != last) begin
                diff = int'(uut.count) - int'(last);
                check_value("step size", 1, (diff < 0) ? -diff : diff);
                last = uut.count;
            end
            check_value("count in bounds", 1,
                        32'(uut.count >= keep_min && uut.count <= keep_max));
            if (seen_max && uut.count == keep_min) seen_min = 1'b1; // Back down from max
            if (uut.count == keep_max) seen_max = 1'b1;
            if (an == 4'b1101) begin
                check_value("tens digit",
                            32'((int'(m_count) / 10 == 1) ? seg_one : seg_zero),
                            32'(segs));
            end
        end
        check_value("reached min", 1, 32'(seen_min));
        check_value("reached max", 1, 32'(seen_max));
        finish_test("bounce between bounds", start);
    endtask

    task automatic hold_on_enable_low();
        int                 start;
        int                 n;
        logic [count_w-1:0] held_count;
        logic               held_dir;
        logic               moved;
        start = errors;
        run_cycle(1'b1, 1'b0, 1'b0, keep_max, keep_min);
        held_count = m_count;
        held_dir   = m_up;
        for (n = 0; n < 5 * step_cycles; n++) begin
            run_cycle(1'b1, 1'b0, 1'b0, keep_max, keep_min);
            check_value("count with en low", 32'(held_count), 32'(uut.count));
            check_value("direction with en low", 32'(held_dir), 32'(uut.direction));
        end
        moved = 1'b0;
        for (n = 0; n < 3 * step_cycles; n++) begin
            run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
            if (uut.count != held_count) moved = 1'b1;
        end
        check_value("counting resumed", 1, 32'(moved));
        finish_test("enable hold", start);
    endtask

    task automatic reverse_by_button();
        int                 start;
        int                 n;
        int                 guard;
        int                 used;
        int                 len;
        int                 expected_next;
        logic               dir_before;
        logic               dir_hold;
        logic [count_w-1:0] count_before;
        start = errors;
        align_to_step();
        dir_before = m_up;
        repeat (24) run_cycle(1'b1, 1'b1, 1'b1, keep_max, keep_min);
        repeat (16) run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
        check_value("direction after press", 32'(!dir_before), 32'(uut.direction));
        count_before = m_count;
        if (count_before == keep_max) begin
            expected_next = int'(count_before) - 1;
        end else if (count_before == keep_min) begin
            expected_next = int'(count_before) + 1;
        end else if (!dir_before) begin
            expected_next = int'(count_before) + 1; // Now counting up
        end else begin
            expected_next = int'(count_before) - 1;
        end
        guard = 0;
        while (m_count == count_before && guard < 2 * step_cycles) begin
            run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
            guard++;
        end
        check_value("step after flip", expected_next, 32'(uut.count));
        // Glitches stay inside one step period so only a flip could move the direction
        for (n = 0; n < 3; n++) begin
            align_to_step();
            dir_hold = m_up;
            used     = 0;
            while (used < step_cycles - 18) begin
                len = rand_range(1, 11);
                repeat (len) run_cycle(1'b1, 1'b1, 1'b1, keep_max, keep_min);
                repeat (5) run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
                used += len + 5;
            end
            check_value("direction after glitches", 32'(dir_hold), 32'(uut.direction));
        end
        finish_test("flip button", start);
    endtask

    task automatic freeze_outside_bounds();
        int                 start;
        int                 n;
        int                 phase;
        int                 c;
        int                 lo;
        int                 hi;
        logic               pressing;
        logic [count_w-1:0] set_max;
        logic [count_w-1:0] set_min;
        logic [count_w-1:0] held_count;
        logic               held_dir;
        start = errors;
        for (phase = 0; phase < 2; phase++) begin
            if (phase == 0) begin
                lo = rand_range(0, 15);
                hi = lo; // Empty range
            end else begin
                c = int'(uut.count);
                if (c >= 2) begin
                    lo = rand_range(0, c - 2);
                    hi = rand_range(lo + 1, c - 1);
                end else begin
                    lo = rand_range(c + 1, 14);
                    hi = rand_range(lo + 1, 15);
                end
            end
            set_min = count_w'(lo);
            set_max = count_w'(hi);
            run_cycle(1'b1, 1'b1, 1'b0, set_max, set_min);
            held_count = m_count;
            held_dir   = m_up;
            for (n = 0; n < 3 * step_cycles; n++) begin
                pressing = (n % step_cycles) >= step_cycles / 4
                        && (n % step_cycles) < 3 * step_cycles / 4;
                run_cycle(1'b1, 1'b1, pressing, set_max, set_min);
                check_value("frozen count", 32'(held_count), 32'(uut.count));
                check_value("frozen direction", 32'(held_dir), 32'(uut.direction));
            end
        end
        run_cycle(1'b1, 1'b1, 1'b0, keep_max, keep_min);
        finish_test("frozen bounds", start);
    endtask

    task automatic random_against_model();
        int                 start;
        int                 n;
        logic               run_en;
        logic               run_flip;
        logic [count_w-1:0] hi;
        logic [count_w-1:0] lo;
        start    = errors;
        run_en   = 1'b1;
        run_flip = 1'b0;
        hi       = keep_max;
        lo       = keep_min;
        for (n = 0; n < len_random; n++) begin
            if (rand_range(0, 31) == 0) run_en = !run_en;
            if (rand_range(0, 15) == 0) run_flip = !run_flip;
            if (rand_range(0, 199) == 0) begin
                lo = count_w'(rand_range(0, 15));
                hi = count_w'(rand_range(0, 15));
            end
            run_cycle(1'b1, run_en, run_flip, hi, lo);
        end
        finish_test("random run against model", start);
    endtask

    initial begin
        seed         = 59530;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        en           = 1'b0;
        flip         = 1'b0;
        bound_max    = '0;
        bound_min    = '0;
        reset_and_scan();
        bounce_between_bounds();
        hold_on_enable_low();
        reverse_by_button();
        freeze_outside_bounds();
        random_against_model();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
